// ==== src/datapathPkg.sv ====
/* shared types for the single-bus datapath: the data word, the register number,
   the ALU operation codes and the two views of an instruction word */
package datapathPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0] regIndexT;

    typedef enum logic [3:0] {
        opAdd = 4'd0,
        opSub = 4'd1,
        opAnd = 4'd2,
        opOr  = 4'd3,
        opShr = 4'd4,
        opShl = 4'd5,
        opRor = 4'd6,
        opRol = 4'd7,
        opNeg = 4'd8,
        opNot = 4'd9,
        opMul = 4'd10,
        opDiv = 4'd11
    } aluOpE;

    // three-register form, e.g. add ra, rb, rc
    typedef struct packed {
        logic [4:0] opcode;
        regIndexT ra;
        regIndexT rb;
        regIndexT rc;
        logic [14:0] unused;
    } rFormatS;

    // register plus constant form, e.g. addi ra, rb, c
    typedef struct packed {
        logic [4:0] opcode;
        regIndexT ra;
        regIndexT rb;
        logic spare;         // bit 18 sits outside the constant
        logic [17:0] c18;
    } iFormatS;

    typedef union packed {
        rFormatS rForm;
        iFormatS iForm;
    } instrU;

endpackage

// ==== src/registerFile.sv ====
/* sixteen general registers R0..R15 with one write port and one
   combinational read port, both addressed by the select-and-encode block */
module registerFile (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 writeEnable,
    input  datapathPkg::regIndexT writeIndex,
    input  datapathPkg::regIndexT readIndex,
    input  datapathPkg::wordT    writeData,
    output datapathPkg::wordT    readData
);

    datapathPkg::wordT regs [16];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // R0 is a normal register here, the zero behaviour lives in the bus path
    assign readData = regs[readIndex];

endmodule

// ==== src/selectEncode.sv ====
/* turns the IR register fields and the gra/grb/grc strobes into one register
   index for the register file, and builds the sign-extended immediate for cOut */
module selectEncode (
    input  datapathPkg::instrU    instr,
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  rIn,
    input  logic                  rOut,
    input  logic                  baOut,
    output logic                  writeEnable,
    output datapathPkg::regIndexT regIndex,
    output logic                  readZero,
    output datapathPkg::wordT     immediate
);

    datapathPkg::regIndexT raField;
    datapathPkg::regIndexT rbField;
    datapathPkg::regIndexT rcField;

    assign raField = instr.rForm.ra;
    assign rbField = instr.rForm.rb;
    assign rcField = instr.rForm.rc;

    // only one field strobe is raised at a time, so a plain OR does the select
    assign regIndex = ({4{gra}} & raField)
                    | ({4{grb}} & rbField)
                    | ({4{grc}} & rcField);

    assign writeEnable = rIn;

    // base-address read, r0 stands for the constant zero
    // a plain rOut still reads r0 as stored
    assign readZero = baOut & ~rOut & (regIndex == 4'd0);

    assign immediate = {{14{instr.iForm.c18[17]}}, instr.iForm.c18};

endmodule

// ==== src/aluUnit.sv ====
/* combinational ALU of the datapath
   a comes from Y, b from the bus, the 64-bit result goes to Z
   incPc bypasses the operation code and gives b + 1 for the PC step */
module aluUnit (
    input  datapathPkg::aluOpE aluOp,
    input  logic               incPc,
    input  datapathPkg::wordT  a,
    input  datapathPkg::wordT  b,
    output logic [63:0]        result
);

    logic [4:0] shiftAmt;
    logic [63:0] doubled;
    logic [63:0] rotRight;
    logic [63:0] rotLeft;
    logic signed [63:0] product;
    datapathPkg::wordT quotient;
    datapathPkg::wordT remainder;

    assign shiftAmt = b[4:0];   // rotates by 32 or more wrap around
    assign doubled = {a, a};
    assign rotRight = doubled >> shiftAmt;
    assign rotLeft = doubled << shiftAmt;

    assign product = $signed(a) * $signed(b);

    always_comb begin
        if (b == '0) begin
            quotient = '1;
            remainder = a;
        end else begin
            quotient = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
        end
    end

    always_comb begin
        if (incPc) begin
            result = {32'b0, b + 32'd1};
        end else begin
            case (aluOp)
                datapathPkg::opAdd: begin
                    result = {32'b0, a + b};
                end
                datapathPkg::opSub: begin
                    result = {32'b0, a - b};
                end
                datapathPkg::opAnd: begin
                    result = {32'b0, a & b};
                end
                datapathPkg::opOr: begin
                    result = {32'b0, a | b};
                end
                datapathPkg::opShr: begin
                    result = {32'b0, a >> shiftAmt};
                end
                datapathPkg::opShl: begin
                    result = {32'b0, a << shiftAmt};
                end
                datapathPkg::opRor: begin
                    result = {32'b0, rotRight[31:0]};
                end
                datapathPkg::opRol: begin
                    result = {32'b0, rotLeft[63:32]};
                end
                datapathPkg::opNeg: begin
                    result = {32'b0, -b};
                end
                datapathPkg::opNot: begin
                    result = {32'b0, ~b};
                end
                datapathPkg::opMul: begin
                    result = product;
                end
                datapathPkg::opDiv: begin
                    result = {remainder, quotient};  // HI gets remainder, LO quotient
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

// ==== src/busMux.sv ====
/* picks the one driver of the shared bus from the out strobes
   the sequencer raises at most one strobe, with none the bus is zero */
module busMux (
    input  logic              pcOut,
    input  logic              mdrOut,
    input  logic              zHighOut,
    input  logic              zLowOut,
    input  logic              hiOut,
    input  logic              loOut,
    input  logic              rOut,
    input  logic              cOut,
    input  datapathPkg::wordT pc,
    input  datapathPkg::wordT mdr,
    input  datapathPkg::wordT hi,
    input  datapathPkg::wordT lo,
    input  datapathPkg::wordT regData,
    input  datapathPkg::wordT immediate,
    input  logic [63:0]       z,
    input  logic              readZero,
    output datapathPkg::wordT bus
);

    datapathPkg::wordT regSource;

    assign regSource = readZero ? '0 : regData;   // r0 under baOut

    // and-gate every source with its strobe, then OR them together
    assign bus = ({32{pcOut}} & pc)
               | ({32{mdrOut}} & mdr)
               | ({32{zHighOut}} & z[63:32])
               | ({32{zLowOut}} & z[31:0])
               | ({32{hiOut}} & hi)
               | ({32{loOut}} & lo)
               | ({32{rOut}} & regSource)
               | ({32{cOut}} & immediate);

endmodule

// ==== src/datapath.sv ====
/* single-bus 32-bit datapath, driven cycle by cycle by an external sequencer
   through load strobes, bus-source strobes, field selects and the ALU op */
module datapath (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               marIn,
    input  logic               mdrIn,
    input  logic               yIn,
    input  logic               zIn,
    input  logic               hiIn,
    input  logic               loIn,
    input  logic               rIn,
    input  logic               pcOut,
    input  logic               mdrOut,
    input  logic               zHighOut,
    input  logic               zLowOut,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               rOut,
    input  logic               cOut,
    input  logic               gra,
    input  logic               grb,
    input  logic               grc,
    input  logic               baOut,
    input  logic               read,
    input  logic               incPc,
    input  datapathPkg::aluOpE aluOp,
    input  datapathPkg::wordT  mDataIn,
    output datapathPkg::wordT  busValue,
    output datapathPkg::wordT  marValue,
    output datapathPkg::wordT  mdrValue,
    output datapathPkg::wordT  irValue
);

    datapathPkg::wordT pc, mar, mdr, y, hi, lo;
    datapathPkg::instrU ir;
    logic [63:0] z;

    datapathPkg::wordT bus, regData, immediate, mdrNext;
    datapathPkg::regIndexT regIndex;
    logic regWrite, readZero;
    logic [63:0] aluResult;

    assign mdrNext = read ? mDataIn : bus;   // memory read or bus write-back

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
            y <= '0;
            z <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (pcIn) pc <= bus;
            if (irIn) ir <= bus;
            if (marIn) mar <= bus;
            if (mdrIn) mdr <= mdrNext;
            if (yIn) y <= bus;
            if (zIn) z <= aluResult;
            if (hiIn) hi <= bus;   // filled from Z through zHighOut
            if (loIn) lo <= bus;
        end
    end

    selectEncode selEnc (
        .instr(ir), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
        .baOut(baOut), .writeEnable(regWrite), .regIndex(regIndex),
        .readZero(readZero), .immediate(immediate)
    );

    registerFile regFile (
        .Clock(Clock), .rstN(rstN), .writeEnable(regWrite), .writeIndex(regIndex),
        .readIndex(regIndex), .writeData(bus), .readData(regData)
    );

    aluUnit alu (.aluOp(aluOp), .incPc(incPc), .a(y), .b(bus), .result(aluResult));

    // baOut and rOut both put the selected register on the bus
    busMux busSel (
        .pcOut(pcOut), .mdrOut(mdrOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .hiOut(hiOut), .loOut(loOut), .rOut(rOut | baOut), .cOut(cOut),
        .pc(pc), .mdr(mdr), .hi(hi), .lo(lo), .regData(regData),
        .immediate(immediate), .z(z), .readZero(readZero), .bus(bus)
    );

    assign busValue = bus;
    assign marValue = mar;
    assign mdrValue = mdr;
    assign irValue = ir;

endmodule

// ==== verification/datapath_sva.sv ====
/* concurrent checks on the bus strobes, MAR and the general registers,
   bound into every datapath instance */
module datapathSva (
    input logic              Clock,
    input logic              rstN,
    input logic              pcOut,
    input logic              mdrOut,
    input logic              zHighOut,
    input logic              zLowOut,
    input logic              hiOut,
    input logic              loOut,
    input logic              rOut,
    input logic              cOut,
    input logic              baOut,
    input logic              marIn,
    input logic              rIn,
    input datapathPkg::wordT marValue,
    input datapathPkg::wordT regs [16]
);
    timeunit 1ns;
    timeprecision 10ps;

    // baOut drives the bus too
    oneSource: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0({pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, rOut, cOut, baOut}))
        else $error("more than one bus source raised");

    marHold: assert property (@(posedge Clock) disable iff (!rstN)
        !marIn |=> $stable(marValue))
        else $error("MAR changed without marIn");

    for (genvar i = 0; i < 16; i++) begin : regHold
        regStable: assert property (@(posedge Clock) disable iff (!rstN)
            !rIn |=> $stable(regs[i]))
            else $error("general register %0d changed without rIn", i);
    end

endmodule

bind datapath datapathSva datapathSva_i (
    .Clock(Clock), .rstN(rstN), .pcOut(pcOut), .mdrOut(mdrOut), .zHighOut(zHighOut),
    .zLowOut(zLowOut), .hiOut(hiOut), .loOut(loOut), .rOut(rOut), .cOut(cOut),
    .baOut(baOut), .marIn(marIn), .rIn(rIn), .marValue(marValue), .regs(regFile.regs)
);

// ==== verification/datapathTb.sv ====
/* table-driven testbench for the datapath, plays the external sequencer
   with micro-step tasks and checks results against a reference ALU model */
module datapathTb;
    timeunit 1ns;
    timeprecision 10ps;

    // bit positions of the control strobes inside ctl
    typedef enum int {
        bPcIn, bIrIn, bMarIn, bMdrIn, bYIn, bZIn, bHiIn, bLoIn, bRIn, bPcOut, bMdrOut,
        bZHighOut, bZLowOut, bHiOut, bLoOut, bROut, bCOut, bGra, bGrb, bGrc, bBaOut,
        bRead, bIncPc
    } strobeE;

    localparam int nRows = 24;
    localparam int nFixed = 14;
    localparam int cyclesPerRow = 20;
    localparam int timeoutNs = nRows * cyclesPerRow * 20 * 2;

    logic Clock;
    logic rstN;
    logic [22:0] ctl;
    datapathPkg::aluOpE aluOp;
    datapathPkg::wordT mDataIn;
    datapathPkg::wordT busValue, marValue, mdrValue, irValue;

    // stimulus table: operation, instruction, operands, expected 64-bit result
    datapathPkg::aluOpE rowOp [nRows];
    datapathPkg::instrU rowInstr [nRows];
    datapathPkg::wordT rowA [nRows];
    datapathPkg::wordT rowB [nRows];
    logic [63:0] rowExp [nRows];
    int seed = 93;

    datapath datapath_i (
        .Clock(Clock), .rstN(rstN), .pcIn(ctl[bPcIn]), .irIn(ctl[bIrIn]),
        .marIn(ctl[bMarIn]), .mdrIn(ctl[bMdrIn]), .yIn(ctl[bYIn]), .zIn(ctl[bZIn]),
        .hiIn(ctl[bHiIn]), .loIn(ctl[bLoIn]), .rIn(ctl[bRIn]), .pcOut(ctl[bPcOut]),
        .mdrOut(ctl[bMdrOut]), .zHighOut(ctl[bZHighOut]), .zLowOut(ctl[bZLowOut]),
        .hiOut(ctl[bHiOut]), .loOut(ctl[bLoOut]), .rOut(ctl[bROut]), .cOut(ctl[bCOut]),
        .gra(ctl[bGra]), .grb(ctl[bGrb]), .grc(ctl[bGrc]), .baOut(ctl[bBaOut]),
        .read(ctl[bRead]), .incPc(ctl[bIncPc]), .aluOp(aluOp), .mDataIn(mDataIn),
        .busValue(busValue), .marValue(marValue), .mdrValue(mdrValue), .irValue(irValue)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    function automatic datapathPkg::instrU makeRForm(input logic [4:0] opcode,
            input datapathPkg::regIndexT ra, input datapathPkg::regIndexT rb,
            input datapathPkg::regIndexT rc);
        datapathPkg::instrU w;
        w = '0;
        w.rForm.opcode = opcode;
        w.rForm.ra = ra;
        w.rForm.rb = rb;
        w.rForm.rc = rc;
        return w;
    endfunction

    // expected ALU result, a from Y and b from the bus
    function automatic logic [63:0] refAlu(input datapathPkg::aluOpE op,
            input datapathPkg::wordT a, input datapathPkg::wordT b);
        logic [63:0] r;
        int n;
        n = int'(b[4:0]);
        case (op)
            datapathPkg::opAdd: r = {32'h0, a + b};
            datapathPkg::opSub: r = {32'h0, a - b};
            datapathPkg::opAnd: r = {32'h0, a & b};
            datapathPkg::opOr:  r = {32'h0, a | b};
            datapathPkg::opShr: r = {32'h0, a >> n};
            datapathPkg::opShl: r = {32'h0, a << n};
            datapathPkg::opRor: r = {32'h0, (a >> n) | (a << (32 - n))};
            datapathPkg::opRol: r = {32'h0, (a << n) | (a >> (32 - n))};
            datapathPkg::opNeg: r = {32'h0, 32'h0 - b};
            datapathPkg::opNot: r = {32'h0, ~b};
            datapathPkg::opMul: r = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            datapathPkg::opDiv: begin
                if (b == 32'h0) r = {a, 32'hFFFF_FFFF};   // divide by zero
                else r = {$signed(a) % $signed(b), $signed(a) / $signed(b)};
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // one sequencer cycle, up to four strobes raised from the falling edge on
    task automatic step(input int s0 = -1, input int s1 = -1, input int s2 = -1,
                        input int s3 = -1);
        @(negedge Clock);
        ctl = '0;
        if (s0 >= 0) ctl |= 23'd1 << s0;
        if (s1 >= 0) ctl |= 23'd1 << s1;
        if (s2 >= 0) ctl |= 23'd1 << s2;
        if (s3 >= 0) ctl |= 23'd1 << s3;
    endtask

    task automatic checkValue(input string name, input datapathPkg::wordT expected,
                              input datapathPkg::wordT actual);
        assert (actual === expected) else begin
            $display("ERR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic checkBus(input string name, input datapathPkg::wordT expected);
        #1;   // let the combinational bus settle
        checkValue(name, expected, busValue);
    endtask

    task automatic loadMdr(input datapathPkg::wordT value);
        step(bRead, bMdrIn);
        mDataIn = value;
    endtask

    task automatic loadIr(input datapathPkg::instrU word);
        loadMdr(word);
        step(bMdrOut, bIrIn);
        checkValue("mdrValue", word, mdrValue);
    endtask

    // leaves IR holding an instruction whose ra is idx
    task automatic writeReg(input datapathPkg::regIndexT idx, input datapathPkg::wordT value);
        loadIr(makeRForm(5'd0, idx, 4'd0, 4'd0));
        loadMdr(value);
        step(bMdrOut, bGra, bRIn);
    endtask

    task automatic setRow(input int i, input datapathPkg::aluOpE op, input datapathPkg::wordT a,
                          input datapathPkg::wordT b, input logic [63:0] expected);
        rowOp[i] = op;
        rowInstr[i] = makeRForm({1'b0, op}, 4'(4 + i % 10), 4'd2, 4'd3);
        rowA[i] = a;
        rowB[i] = b;
        rowExp[i] = expected;
    endtask

    task automatic buildTable();
        datapathPkg::aluOpE op;
        datapathPkg::wordT a;
        datapathPkg::wordT b;
        setRow(0, datapathPkg::opAdd, 32'd5, 32'd7, 64'h0000_0000_0000_000C);
        setRow(1, datapathPkg::opSub, 32'd3, 32'd5, 64'h0000_0000_FFFF_FFFE);
        setRow(2, datapathPkg::opAnd, 32'hF0F0_F0F0, 32'hFF00_FF00, 64'h0000_0000_F000_F000);
        setRow(3, datapathPkg::opOr, 32'h1234_0000, 32'h0000_5678, 64'h0000_0000_1234_5678);
        setRow(4, datapathPkg::opShr, 32'h8000_0000, 32'd4, 64'h0000_0000_0800_0000);
        setRow(5, datapathPkg::opShl, 32'h0000_0001, 32'd31, 64'h0000_0000_8000_0000);
        setRow(6, datapathPkg::opRor, 32'h0000_0001, 32'd33, 64'h0000_0000_8000_0000);
        setRow(7, datapathPkg::opRol, 32'h8000_0001, 32'd36, 64'h0000_0000_0000_0018);
        setRow(8, datapathPkg::opNeg, 32'h55, 32'd1, 64'h0000_0000_FFFF_FFFF);
        setRow(9, datapathPkg::opNot, 32'h55, 32'h0F0F_0000, 64'h0000_0000_F0F0_FFFF);
        setRow(10, datapathPkg::opMul, 32'hFFFF_FFFD, 32'd7, 64'hFFFF_FFFF_FFFF_FFEB);
        setRow(11, datapathPkg::opMul, 32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000);
        setRow(12, datapathPkg::opDiv, 32'd7, 32'd0, 64'h0000_0007_FFFF_FFFF);
        setRow(13, datapathPkg::opDiv, 32'hFFFF_FFF9, 32'd2, 64'hFFFF_FFFF_FFFF_FFFD);
        for (int i = nFixed; i < nRows; i++) begin
            op = datapathPkg::aluOpE'(4'(i % 12));
            a = $random(seed);
            b = $random(seed);
            setRow(i, op, a, b, refAlu(op, a, b));
        end
    endtask

    // rb and rc as operands, result back to ra, then both Z halves through HI and LO
    task automatic runRow(input int i);
        writeReg(rowInstr[i].rForm.rb, rowA[i]);
        writeReg(rowInstr[i].rForm.rc, rowB[i]);
        loadIr(rowInstr[i]);
        step(bGrb, bROut, bYIn);
        checkValue("irValue", rowInstr[i], irValue);
        step(bGrc, bROut, bZIn);
        aluOp = rowOp[i];
        step(bZLowOut, bGra, bRIn);
        step(bGra, bROut);
        checkBus("busValue (ra)", rowExp[i][31:0]);
        step(bZHighOut, bHiIn);
        step(bZLowOut, bLoIn);
        step(bHiOut);
        checkBus("busValue (HI)", rowExp[i][63:32]);
        step(bLoOut);
        checkBus("busValue (LO)", rowExp[i][31:0]);
    endtask

    initial begin
        datapathPkg::instrU iWord;
        rstN = 1'b0;
        ctl = '0;
        aluOp = datapathPkg::opAdd;
        mDataIn = '0;
        buildTable();
        repeat (5) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        #1;
        checkValue("busValue", 32'h0, busValue);
        checkValue("marValue", 32'h0, marValue);
        checkValue("mdrValue", 32'h0, mdrValue);
        checkValue("irValue", 32'h0, irValue);

        // memory word through MDR into r9 and back
        loadIr(makeRForm(5'd0, 4'd0, 4'd0, 4'd9));
        loadMdr(32'hCAFE_BABE);
        step(bMdrOut, bGrc, bRIn);
        step(bGrc, bROut);
        checkBus("busValue (r9)", 32'hCAFE_BABE);

        for (int i = 0; i < nRows; i++) begin
            runRow(i);
        end

        // addi r6, r2, -16
        writeReg(4'd2, 32'd100);
        iWord = '0;
        iWord.iForm.ra = 4'd6;
        iWord.iForm.rb = 4'd2;
        iWord.iForm.c18 = 18'h3FFF0;
        loadIr(iWord);
        step(bCOut);
        checkBus("busValue (c18)", 32'hFFFF_FFF0);
        step(bGrb, bROut, bYIn);
        step(bCOut, bZIn);
        aluOp = datapathPkg::opAdd;
        step(bZLowOut);
        checkBus("busValue (rb + c)", 32'd84);

        // r0 holds a value but reads zero as a base address
        writeReg(4'd0, 32'h0000_1234);
        step(bGra, bBaOut);
        checkBus("busValue (baOut r0)", 32'h0);
        step(bGra, bROut);
        checkBus("busValue (rOut r0)", 32'h0000_1234);

        loadMdr(32'h40);
        step(bMdrOut, bPcIn);
        step(bPcOut, bIncPc, bZIn);
        step(bZLowOut, bPcIn);
        step(bPcOut, bMarIn);
        checkBus("busValue (PC)", 32'h41);
        step();
        checkValue("marValue", 32'h41, marValue);

        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule

// ==== filelist.f ====
src/datapathPkg.sv
src/registerFile.sv
src/selectEncode.sv
src/aluUnit.sv
src/busMux.sv
src/datapath.sv
verification/datapath_sva.sv
verification/datapathTb.sv

// ==== Makefile ====
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module datapathTb -Mdir obj_dir -f filelist.f
	./obj_dir/VdatapathTb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only --timing --assert --top-module datapathTb -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
